// File: Makefile
# Verilator build, run and lint for the PWM audio path
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TB_TOP    ?= audioPwmTb
RTL_TOP   ?= audioPwmTop
FILE_LIST ?= audioPwmTop.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= ALL CHECKS PASSED

RTL_SRCS := $(filter src/%,$(shell cat $(FILE_LIST)))
SIM_BIN  := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# Pass only when the simulation prints the pass line
run: build
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

// File: audioPwmTop.f
src/audioPkg.sv
src/audioSampleIf.sv
src/audioRstSync.sv
src/audioWordDecoder.sv
src/audioGainStage.sv
src/audioPwmModulator.sv
src/audioPwmTop.sv
sim/audioPwmChecker.sv
sim/audioPwmTb.sv

// File: sim/audioPwmChecker.sv
`timescale 1ns/1ps
`default_nettype none

// Watches the DUT outputs and measures the duty of each PWM period
module audioPwmChecker
(
    input  wire logic           wAudioClk,
    input  wire logic           sampleReq,
    input  wire logic           pwmOut,
    // Requests from the stimulus loop
    input  wire logic           checkReq,
    input  wire logic           quietReq,
    input  wire logic [15:0]    expDuty,
    input  wire logic [7:0]     testId,
    output logic                checkDone,
    output logic [15:0]         passCount,
    output logic [15:0]         failCount
);

    localparam logic [1:0] stIdle      = 2'd0;
    localparam logic [1:0] stWaitStart = 2'd1;
    localparam logic [1:0] stCount     = 2'd2;

    logic [1:0]     state;
    // High cycles seen so far in the measured period
    logic [15:0]    highCount;
    // Silence window open and anything seen inside it
    logic           quietSeen;
    logic           quietBad;

    initial
    begin
        state     = stIdle;
        highCount = '0;
        quietSeen = 1'b0;
        quietBad  = 1'b0;
        checkDone = 1'b0;
        passCount = '0;
        failCount = '0;
    end

    // --------------------
    // Silence watch
    // --------------------
    // DUT outputs are read before the edge updates them
    always @(posedge wAudioClk)
    begin
        checkDone <= 1'b0;
        if (quietReq)
        begin
            quietSeen <= 1'b1;
            if (sampleReq || pwmOut)
                quietBad <= 1'b1;
        end
        else if (quietSeen)
        begin
            // Window just closed
            if (quietBad)
            begin
                $display("Test %0d failed: sampleReq or pwmOut went high while lock was low",
                         testId);
                failCount <= failCount + 1'b1;
            end
            else
            begin
                $display("Test %0d passed: outputs stayed low while lock was low", testId);
                passCount <= passCount + 1'b1;
            end
            quietSeen <= 1'b0;
            quietBad  <= 1'b0;
            checkDone <= 1'b1;
        end

        // --------------------
        // Duty measurement
        // --------------------
        case (state)
            stIdle:
            begin
                if (checkReq)
                    state <= stWaitStart;
            end
            stWaitStart:
            begin
                // Period starts in the sampleReq cycle
                if (sampleReq)
                begin
                    highCount <= {15'd0, pwmOut};
                    state     <= stCount;
                end
            end
            default:
            begin
                if (sampleReq)
                begin
                    // Measured period ends where the next one begins
                    if (highCount != expDuty)
                    begin
                        $display("** Error at %0t: test %0d pwmOut duty expected %0d, actual %0d",
                                 $time, testId, expDuty, highCount);
                        failCount <= failCount + 1'b1;
                    end
                    else
                    begin
                        $display("Test %0d passed: pwmOut duty %0d", testId, highCount);
                        passCount <= passCount + 1'b1;
                    end
                    checkDone <= 1'b1;
                    state     <= stIdle;
                end
                else
                    highCount <= highCount + {15'd0, pwmOut};
            end
        endcase
    end

endmodule

`default_nettype wire

// File: sim/audioPwmTb.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench top for the PWM audio path
module audioPwmTb;

    localparam int pPwmBits   = 8;
    localparam int clkPeriod  = 20;
    localparam int driveDelay = 2;
    // Three PWM periods
    localparam int waitLimit  = 3 * (2 ** pPwmBits);

    logic                               wAudioClk;
    logic                               rstN;
    logic                               pllLock;
    logic                               wordValid;
    logic [audioPkg::wordWidth-1:0]     inWord;
    logic                               sampleReq;
    logic                               pwmOut;

    // Link to the checker
    logic                               checkReq;
    logic                               quietReq;
    logic [15:0]                        expDuty;
    logic [7:0]                         testId;
    logic                               checkDone;
    logic [15:0]                        passCount;
    logic [15:0]                        failCount;

    int                                 otherErrors;
    bit                                 runAborted;
    bit                                 fileDone;
    int                                 fd;
    int                                 code;
    logic [7:0]                         kind;
    logic [31:0]                        value;
    int                                 expected;

    audioPwmTop #(
        .pPwmBits   (pPwmBits)
    ) dut_i (
        .wAudioClk  (wAudioClk),
        .rstN       (rstN),
        .pllLock    (pllLock),
        .wordValid  (wordValid),
        .inWord     (inWord),
        .sampleReq  (sampleReq),
        .pwmOut     (pwmOut)
    );

    audioPwmChecker checker_i
    (
        .wAudioClk  (wAudioClk),
        .sampleReq  (sampleReq),
        .pwmOut     (pwmOut),
        .checkReq   (checkReq),
        .quietReq   (quietReq),
        .expDuty    (expDuty),
        .testId     (testId),
        .checkDone  (checkDone),
        .passCount  (passCount),
        .failCount  (failCount)
    );

    initial
    begin
        wAudioClk = 1'b0;
        forever #(clkPeriod / 2) wAudioClk = ~wAudioClk;
    end

    // --------------------
    // Word builders
    // --------------------
    function automatic logic [audioPkg::wordWidth-1:0] sampleWord(input logic [15:0] s);
        return {audioPkg::kindSample, 1'b0, s};
    endfunction

    function automatic logic [audioPkg::wordWidth-1:0] gainWord(input logic [7:0] g);
        return {audioPkg::kindGain, 9'd0, g};
    endfunction

    // --------------------
    // Waits
    // --------------------
    // Returns just after the edge that raised sampleReq
    task automatic waitSampleReq(input string what);
        int     cycles;
        logic   seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < waitLimit)
        begin
            @(posedge wAudioClk);
            #driveDelay;
            seen = sampleReq;
            cycles++;
        end
        if (!seen)
        begin
            $display("Timeout: no sampleReq pulse within %0d cycles %s", waitLimit, what);
            otherErrors++;
            runAborted = 1'b1;
        end
    endtask

    task automatic awaitResult();
        int     cycles;
        logic   seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < waitLimit)
        begin
            @(posedge wAudioClk);
            #driveDelay;
            seen = checkDone;
            cycles++;
        end
        if (!seen)
        begin
            $display("Timeout: checker gave no result for test %0d", testId);
            otherErrors++;
            runAborted = 1'b1;
        end
    endtask

    // --------------------
    // Stimulus actions
    // --------------------
    // One-cycle word strobe that may arm the checker for the next period
    task automatic driveWord(input logic [audioPkg::wordWidth-1:0] word, input logic arm);
        wordValid = 1'b1;
        inWord    = word;
        checkReq  = arm;
        @(posedge wAudioClk);
        #driveDelay;
        wordValid = 1'b0;
        checkReq  = 1'b0;
    endtask

    task automatic checkSilence(input int cycles);
        testId++;
        quietReq = 1'b1;
        repeat (cycles) @(posedge wAudioClk);
        #driveDelay;
        quietReq = 1'b0;
        awaitResult();
    endtask

    // First period after lock is measured without any word
    task automatic releaseLock(input int exp);
        testId++;
        expDuty  = 16'(exp);
        pllLock  = 1'b1;
        checkReq = 1'b1;
        @(posedge wAudioClk);
        #driveDelay;
        checkReq = 1'b0;
        waitSampleReq("after lock rose");
        if (!runAborted)
            awaitResult();
    endtask

    task automatic setGain(input logic [7:0] g);
        waitSampleReq("before a gain command");
        if (!runAborted)
        begin
            @(posedge wAudioClk);
            #driveDelay;
            driveWord(gainWord(g), 1'b0);
        end
    endtask

    task automatic playSample(input logic [15:0] s, input int exp);
        testId++;
        expDuty = 16'(exp);
        waitSampleReq("before a sample");
        if (!runAborted)
        begin
            @(posedge wAudioClk);
            #driveDelay;
            driveWord(sampleWord(s), 1'b1);
            awaitResult();
        end
    endtask

    // Upper half first and lower half a few cycles later in the same period
    task automatic playTwoSamples(input logic [31:0] pair, input int exp);
        testId++;
        expDuty = 16'(exp);
        waitSampleReq("before a sample pair");
        if (!runAborted)
        begin
            @(posedge wAudioClk);
            #driveDelay;
            driveWord(sampleWord(pair[31:16]), 1'b1);
            repeat (3) @(posedge wAudioClk);
            #driveDelay;
            driveWord(sampleWord(pair[15:0]), 1'b0);
            awaitResult();
        end
    endtask

    task automatic skipCommentLine();
        int ch;
        ch = 0;
        while (ch != "\n" && ch != -1)
            ch = $fgetc(fd);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial
    begin
        rstN        = 1'b0;
        pllLock     = 1'b0;
        wordValid   = 1'b0;
        inWord      = '0;
        checkReq    = 1'b0;
        quietReq    = 1'b0;
        expDuty     = '0;
        testId      = '0;
        otherErrors = 0;
        runAborted  = 1'b0;
        fileDone    = 1'b0;

        fd = $fopen("sim/audio_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file sim/audio_stimulus.txt");
            otherErrors++;
            fileDone = 1'b1;
        end

        // Board reset for two cycles while lock stays low
        repeat (2) @(posedge wAudioClk);
        #driveDelay;
        rstN = 1'b1;

        while (!fileDone && !runAborted)
        begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1)
                fileDone = 1'b1;
            else if (kind == "#")
                skipCommentLine();
            else
            begin
                code = $fscanf(fd, "%h %d", value, expected);
                if (code != 2)
                begin
                    $display("Malformed stimulus line of kind %c", kind);
                    otherErrors++;
                    fileDone = 1'b1;
                end
                else
                begin
                    case (kind)
                        "Q": checkSilence(int'(value));
                        "L": releaseLock(expected);
                        "G": setGain(value[7:0]);
                        "S": playSample(value[15:0], expected);
                        "D": playTwoSamples(value, expected);
                        default:
                        begin
                            $display("Unknown stimulus kind %c", kind);
                            otherErrors++;
                        end
                    endcase
                end
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("Summary: %0d passed, %0d failed, %0d other errors",
                 passCount, failCount, otherErrors);
        if (passCount > 0 && failCount == 0 && otherErrors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/audio_stimulus.txt
# Columns: kind, value in hex, expected duty in decimal
# Kinds: Q silence cycles with lock low, L lock up, G gain, S sample, D two samples
# Lock gating, 0x258 = 600 cycles of silence
Q 258 0
L 0 128
# Unity gain
S 8000 0
S 0000 128
S 7fff 255
S 1234 146
S c000 64
# Half gain
G 40 0
S 7fff 191
S 8000 64
S 2000 144
S f000 120
# Near double gain, large values clip
G ff 0
S 6000 255
S a000 0
S 0100 129
S ff00 126
# Zero gain mutes
G 00 0
S 7fff 128
S 8000 128
S 1234 128
# Back to unity, second sample of a pair wins
G 80 0
D 80007fff 255
D 7fff8000 0
D 0000c000 64

// File: src/audioGainStage.sv
`timescale 1ns/1ps
`default_nettype none

// Gain multiply and saturate, two pipeline stages
module audioGainStage
(
    input  wire logic                                   wAudioClk,
    input  wire logic                                   audioRstN,
    input  wire logic                                   sampleStb,
    input  wire logic signed [audioPkg::sampleWidth-1:0] sampleData,
    input  wire logic                                   gainStb,
    input  wire logic [audioPkg::gainWidth-1:0]         gainValue,
    audioSampleIf.gain                                  outSample
);

    // Full product of signed sample and unsigned gain
    localparam int prodWidth   = audioPkg::sampleWidth + audioPkg::gainWidth + 1;
    // Q1.7 gain has 7 fraction bits
    localparam int fracBits    = audioPkg::gainWidth - 1;
    localparam int scaledWidth = prodWidth - fracBits;

    logic [audioPkg::gainWidth-1:0]     gainReg;
    logic signed [prodWidth-1:0]        productReg;
    logic                               productValid;
    logic                               productMuted;
    logic signed [scaledWidth-1:0]      scaled;
    logic                               overflow;
    logic signed [audioPkg::sampleWidth-1:0] satValue;

    // --------------------
    // Gain register
    // --------------------
    // New gain applies to samples strobed after it
    always_ff @(posedge wAudioClk or negedge audioRstN)
    begin
        if (!audioRstN)
            gainReg <= audioPkg::gainUnity;
        else if (gainStb)
            gainReg <= gainValue;
    end

    // --------------------
    // Multiply stage
    // --------------------
    always_ff @(posedge wAudioClk)
    begin
        // Zero-extend gain so the multiply stays signed
        if (sampleStb)
            productReg <= sampleData * $signed({1'b0, gainReg});
    end

    always_ff @(posedge wAudioClk or negedge audioRstN)
    begin
        if (!audioRstN)
        begin
            productValid <= 1'b0;
            productMuted <= 1'b0;
        end
        else
        begin
            productValid <= sampleStb;
            if (sampleStb)
                productMuted <= (gainReg == '0);
        end
    end

    // --------------------
    // Shift and saturate stage
    // --------------------
    assign scaled   = productReg[prodWidth-1:fracBits];
    // Bits above the sample sign must all match it
    assign overflow = (scaled[scaledWidth-1:audioPkg::sampleWidth-1] !=
                       {(scaledWidth-audioPkg::sampleWidth+1){scaled[scaledWidth-1]}});
    // Rail of the same sign
    assign satValue = scaled[scaledWidth-1] ? 16'sh8000 : 16'sh7fff;

    always_ff @(posedge wAudioClk)
    begin
        if (productValid)
            outSample.data <= overflow ? satValue : scaled[audioPkg::sampleWidth-1:0];
    end

    always_ff @(posedge wAudioClk or negedge audioRstN)
    begin
        if (!audioRstN)
        begin
            outSample.valid   <= 1'b0;
            outSample.clipped <= 1'b0;
            outSample.muted   <= 1'b0;
        end
        else
        begin
            outSample.valid <= productValid;
            // Flags travel with their sample
            if (productValid)
            begin
                outSample.clipped <= overflow;
                outSample.muted   <= productMuted;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/audioPkg.sv
`default_nettype none

package audioPkg;

    // --------------------
    // Word and data widths
    // --------------------
    localparam int sampleWidth = 16;
    localparam int gainWidth   = 8;
    localparam int wordWidth   = 18;

    // Gain is Q1.7, so 128 means unity
    localparam logic [gainWidth-1:0] gainUnity = 8'd128;

    // Top bit of every input word
    typedef enum logic
    {
        kindSample = 1'b0,
        kindGain   = 1'b1
    } wordKind_t;

    // --------------------
    // Two views of one input word
    // --------------------
    typedef struct packed
    {
        wordKind_t                      kind;
        logic                           pad;
        logic signed [sampleWidth-1:0]  sample;
    } sampleWord_t;

    typedef struct packed
    {
        wordKind_t                      kind;
        logic [8:0]                     pad;
        logic [gainWidth-1:0]           gain;
    } gainWord_t;

    typedef union packed
    {
        sampleWord_t                    sample;
        gainWord_t                      gain;
    } audioWord_u;

endpackage

`default_nettype wire

// File: src/audioPwmModulator.sv
`timescale 1ns/1ps
`default_nettype none

// Output side, counter-based PWM
module audioPwmModulator #(
    parameter int pPwmBits = 8
)(
    input  wire logic   wAudioClk,
    input  wire logic   audioRstN,
    audioSampleIf.mod   inSample,
    output logic        sampleReq,
    output logic        pwmOut
);

    // Silent level in the middle of the range
    localparam logic [pPwmBits-1:0] halfScale = {1'b1, {(pPwmBits-1){1'b0}}};

    logic [pPwmBits-1:0]                        pwmCnt;
    logic signed [audioPkg::sampleWidth-1:0]    heldData;
    logic                                       heldClipped;
    logic                                       heldMuted;
    logic [audioPkg::sampleWidth-1:0]           offsetSample;
    logic [pPwmBits-1:0]                        newDuty;
    logic [pPwmBits-1:0]                        dutyReg;
    logic [pPwmBits-1:0]                        dutyNow;

    // --------------------
    // Held sample
    // --------------------
    // Last one wins without back-pressure
    always_ff @(posedge wAudioClk or negedge audioRstN)
    begin
        if (!audioRstN)
        begin
            heldData    <= '0;
            heldClipped <= 1'b0;
            heldMuted   <= 1'b0;
        end
        else if (inSample.valid)
        begin
            heldData    <= inSample.data;
            heldClipped <= inSample.clipped;
            heldMuted   <= inSample.muted;
        end
    end

    // --------------------
    // Duty from sample
    // --------------------
    // Offset binary by flipping the sign bit
    assign offsetSample = {~heldData[audioPkg::sampleWidth-1],
                           heldData[audioPkg::sampleWidth-2:0]};

    always_comb
    begin
        if (heldMuted)
            newDuty = halfScale;
        else if (heldClipped)
            newDuty = heldData[audioPkg::sampleWidth-1] ? '0 : '1;  // Straight to a rail
        else
            newDuty = offsetSample[audioPkg::sampleWidth-1 -: pPwmBits];
    end

    // New duty takes effect in the period it was latched for
    assign dutyNow = (pwmCnt == '0) ? newDuty : dutyReg;

    // --------------------
    // Counter and outputs
    // --------------------
    always_ff @(posedge wAudioClk or negedge audioRstN)
    begin
        if (!audioRstN)
        begin
            pwmCnt    <= '0;
            dutyReg   <= halfScale;
            sampleReq <= 1'b0;
            pwmOut    <= 1'b0;
        end
        else
        begin
            pwmCnt    <= pwmCnt + 1'b1;
            dutyReg   <= dutyNow;
            // Ask for the next sample at period start
            sampleReq <= (pwmCnt == '0);
            pwmOut    <= (pwmCnt < dutyNow);
        end
    end

endmodule

`default_nettype wire

// File: src/audioPwmTop.sv
`timescale 1ns/1ps
`default_nettype none

// PWM audio output path, top level
module audioPwmTop #(
    parameter int pPwmBits = 8
)(
    input  wire logic                               wAudioClk,
    input  wire logic                               rstN,
    input  wire logic                               pllLock,
    input  wire logic                               wordValid,
    input  wire logic [audioPkg::wordWidth-1:0]     inWord,
    output logic                                    sampleReq,
    output logic                                    pwmOut
);

    // Internal reset held low until lock is stable
    logic                                       audioRstN;

    // Decoder to gain stage
    logic                                       sampleStb;
    logic signed [audioPkg::sampleWidth-1:0]    sampleData;
    logic                                       gainStb;
    logic [audioPkg::gainWidth-1:0]             gainValue;

    // Gain stage to modulator
    audioSampleIf sampleIf_i ();

    // --------------------
    // Reset
    // --------------------
    audioRstSync rstSync_i
    (
        .wAudioClk  (wAudioClk),
        .rstN       (rstN),
        .pllLock    (pllLock),
        .audioRstN  (audioRstN)
    );

    // --------------------
    // Datapath
    // --------------------
    audioWordDecoder decoder_i
    (
        .wAudioClk  (wAudioClk),
        .audioRstN  (audioRstN),
        .wordValid  (wordValid),
        .inWord     (inWord),
        .sampleStb  (sampleStb),
        .sampleData (sampleData),
        .gainStb    (gainStb),
        .gainValue  (gainValue)
    );

    audioGainStage gain_i
    (
        .wAudioClk  (wAudioClk),
        .audioRstN  (audioRstN),
        .sampleStb  (sampleStb),
        .sampleData (sampleData),
        .gainStb    (gainStb),
        .gainValue  (gainValue),
        .outSample  (sampleIf_i.gain)
    );

    audioPwmModulator #(
        .pPwmBits   (pPwmBits)
    ) modulator_i (
        .wAudioClk  (wAudioClk),
        .audioRstN  (audioRstN),
        .inSample   (sampleIf_i.mod),
        .sampleReq  (sampleReq),
        .pwmOut     (pwmOut)
    );

endmodule

`default_nettype wire

// File: src/audioRstSync.sv
`timescale 1ns/1ps
`default_nettype none

// Audio domain reset, held until the clock manager reports lock
module audioRstSync
(
    input  wire logic   wAudioClk,
    input  wire logic   rstN,
    input  wire logic   pllLock,
    output logic        audioRstN
);

    // --------------------
    // Lock resync
    // --------------------
    // Lock comes from another timing domain
    logic lockMeta;
    // Settled copy of lock
    logic lockSync;

    // Board reset clears both flops at once
    // Release happens on the second edge after lock is seen
    always_ff @(posedge wAudioClk or negedge rstN)
    begin
        if (!rstN)
        begin
            lockMeta <= 1'b0;
            lockSync <= 1'b0;
        end
        else
        begin
            lockMeta <= pllLock;
            lockSync <= lockMeta;
        end
    end

    // --------------------
    // Reset out
    // --------------------
    // Low while board reset is low or lock is missing
    // Losing lock drops it again after two edges
    assign audioRstN = lockSync;

endmodule

`default_nettype wire

// File: src/audioSampleIf.sv
`timescale 1ns/1ps
`default_nettype none

// Processed samples from the gain stage to the modulator
interface audioSampleIf;

    // One-cycle pulse per processed sample
    logic                                       valid;
    logic signed [audioPkg::sampleWidth-1:0]    data;
    // Saturation happened on this sample
    logic                                       clipped;
    // Gain was zero for this sample
    logic                                       muted;

    // Producer side
    modport gain
    (
        output valid,
        output data,
        output clipped,
        output muted
    );

    // Consumer side
    modport mod
    (
        input  valid,
        input  data,
        input  clipped,
        input  muted
    );

endinterface

`default_nettype wire

// File: src/audioWordDecoder.sv
`timescale 1ns/1ps
`default_nettype none

// Input side of the audio path
module audioWordDecoder
(
    input  wire logic                                   wAudioClk,
    input  wire logic                                   audioRstN,
    input  wire logic                                   wordValid,
    input  wire audioPkg::audioWord_u                   inWord,
    output logic                                        sampleStb,
    output logic signed [audioPkg::sampleWidth-1:0]     sampleData,
    output logic                                        gainStb,
    output logic [audioPkg::gainWidth-1:0]              gainValue
);

    // --------------------
    // Word register
    // --------------------
    // Last strobed word, read through either view
    audioPkg::audioWord_u wordReg;

    // Kind bit of the incoming word, seen from each view
    logic isSampleWord;
    logic isGainWord;

    assign isSampleWord = (inWord.sample.kind == audioPkg::kindSample);
    assign isGainWord   = (inWord.gain.kind == audioPkg::kindGain);

    // Captured on every word strobe
    always_ff @(posedge wAudioClk)
    begin
        if (wordValid)
        begin
            wordReg <= inWord;
        end
    end

    // --------------------
    // Strobes
    // --------------------
    // Exactly one of the two fires one cycle after wordValid
    always_ff @(posedge wAudioClk or negedge audioRstN)
    begin
        if (!audioRstN)
        begin
            sampleStb <= 1'b0;
            gainStb   <= 1'b0;
        end
        else
        begin
            sampleStb <= wordValid && isSampleWord;
            gainStb   <= wordValid && isGainWord;
        end
    end

    // --------------------
    // Field views
    // --------------------
    // Signed sample in the low 16 bits
    assign sampleData = wordReg.sample.sample;

    // Gain in the low 8 bits with pad bits ignored
    assign gainValue  = wordReg.gain.gain;

endmodule

`default_nettype wire
